/* build.f */
+incdir+.
cache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
axi_burst_reader.sv
icache_ctrl.sv
cache_controller.sv
tb_clock_gen.sv
tb_axi_mem.sv
tb_cache_controller.sv

/* Makefile */
# Verilator simulation of the instruction cache controller

VERILATOR ?= verilator
TOP       ?= tb_cache_controller
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_cache_controller.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_cache_controller;
	import cache_pkg::*;

	localparam int NUM_ROWS    = 14;
	localparam int CLK_NS      = 40;
	localparam int ROW_CYCLES  = 300;
	localparam int HIT_LATENCY = 2;

	logic       clk;
	logic       arst_n;
	logic       ibus_read;
	addr_t      ibus_addr;
	logic       ibus_flush;
	fetch_t     ibus_rdata;
	logic       ibus_valid;
	logic [3:0] arid;
	addr_t      araddr;
	logic [3:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic       arvalid;
	logic       arready;
	logic [3:0] rid;
	word_t      rdata;
	logic [1:0] rresp;
	logic       rlast;
	logic       rvalid;
	logic       rready;
	logic       stall_en;
	int         ar_count;
	addr_t      last_araddr;
	logic [3:0] last_arlen;
	logic [3:0] last_arid;
	logic [2:0] last_arsize;
	logic [1:0] last_arburst;

	// One fetch per row with a flush pulse first where flagged
	addr_t row_addr [NUM_ROWS] = '{
		32'h0000_1040, 32'h0000_1048, 32'h0000_1058, 32'h0000_1050,
		32'h0000_3040, 32'h0000_1040, 32'h0000_20A0, 32'h0000_1048,
		32'h0000_20A8, 32'h0000_4400, 32'h0000_4418, 32'h0000_5400,
		32'h8000_0138, 32'h0000_4408
	};
	logic row_flush [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0};
	logic row_stall [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1};
	logic row_miss  [NUM_ROWS];

	int errors;
	int rows_failed;
	int exp_bursts;

	tb_clock_gen clk_gen (.clk);
	cache_controller UUT (.*);
	tb_axi_mem mem (.*);

	function automatic word_t mem_word(input addr_t a);
		return a ^ 32'h5A5A0000;
	endfunction

	// Lower address in the low half
	function automatic fetch_t expected_fetch(input addr_t a);
		return {mem_word(a + 32'd4), mem_word(a)};
	endfunction

	function automatic addr_t line_base(input addr_t a);
		return a & ~addr_t'(`CACHE_LINE_WORDS * 4 - 1);
	endfunction

	// Direct-mapped reference of tags and valid bits
	task automatic predict_misses();
		tag_t   model_tag   [`CACHE_SETS];
		logic   model_valid [`CACHE_SETS];
		index_t idx;
		tag_t   tag;
		foreach (model_valid[s]) begin
			model_valid[s] = 1'b0;
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (row_flush[r]) begin
				foreach (model_valid[s]) begin
					model_valid[s] = 1'b0;
				end
			end
			idx = index_t'(row_addr[r] >> `CACHE_OFFSET_LEN);
			tag = tag_t'(row_addr[r] >> (`CACHE_OFFSET_LEN + `CACHE_INDEX_LEN));
			row_miss[r]      = !(model_valid[idx] && model_tag[idx] == tag);
			model_valid[idx] = 1'b1;
			model_tag[idx]   = tag;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic run_row(input int r);
		int     waited;
		int     errors_before;
		fetch_t got;
		errors_before = errors;
		if (row_flush[r]) begin
			@(posedge clk);
			ibus_flush <= 1'b1;
			@(posedge clk);
			ibus_flush <= 1'b0;
		end
		@(posedge clk);
		stall_en  <= row_stall[r];
		ibus_read <= 1'b1;
		ibus_addr <= row_addr[r];
		waited = 0;
		// Values read here are the ones from before this edge
		do begin
			@(posedge clk);
			waited++;
		end while (!ibus_valid);
		got = ibus_rdata;
		ibus_read <= 1'b0;
		exp_bursts += row_miss[r] ? 1 : 0;
		assert (got == expected_fetch(row_addr[r]))
			else report_mismatch("ibus_rdata", got, expected_fetch(row_addr[r]));
		assert (ar_count == exp_bursts)
			else report_mismatch("ar_count", 64'(ar_count), 64'(exp_bursts));
		if (row_miss[r]) begin
			assert (last_araddr == line_base(row_addr[r]))
				else report_mismatch("araddr", 64'(last_araddr), 64'(line_base(row_addr[r])));
			assert (last_arlen == 4'd7)
				else report_mismatch("arlen", 64'(last_arlen), 64'd7);
			assert (last_arsize == 3'd2)
				else report_mismatch("arsize", 64'(last_arsize), 64'd2);
			assert (last_arburst == 2'b01)
				else report_mismatch("arburst", 64'(last_arburst), 64'd1);
			assert (last_arid == 4'd0)
				else report_mismatch("arid", 64'(last_arid), 64'd0);
			// Burst closed on its last beat
			assert (!rready)
				else report_mismatch("rready", 64'(rready), 64'd0);
		end else begin
			// Counted from the edge that first sees ibus_read
			assert (waited - 1 == HIT_LATENCY)
				else report_mismatch("ibus_valid latency", 64'(waited - 1), 64'(HIT_LATENCY));
		end
		if (errors != errors_before) begin
			rows_failed++;
		end
		$display("row %0d addr %h %s: %s", r, row_addr[r], row_miss[r] ? "miss" : "hit",
			(errors == errors_before) ? "pass" : "fail");
	endtask

	initial begin
		#(NUM_ROWS * ROW_CYCLES * CLK_NS);
		$display("Watchdog expired: the DUT never returned ibus_valid, run stopped");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		arst_n      = 1'b0;
		ibus_read   = 1'b0;
		ibus_addr   = '0;
		ibus_flush  = 1'b0;
		stall_en    = 1'b0;
		errors      = 0;
		rows_failed = 0;
		exp_bursts  = 0;
		predict_misses();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		assert (!ibus_valid) else report_mismatch("ibus_valid", 64'(ibus_valid), 64'd0);
		assert (!arvalid) else report_mismatch("arvalid", 64'(arvalid), 64'd0);
		assert (!rready) else report_mismatch("rready", 64'(rready), 64'd0);
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("%0d rows, %0d failed, %0d errors, %0d bursts", NUM_ROWS, rows_failed,
			errors, ar_count);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_axi_mem (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             stall_en,
	input  logic [3:0]       arid,
	input  cache_pkg::addr_t araddr,
	input  logic [3:0]       arlen,
	input  logic [2:0]       arsize,
	input  logic [1:0]       arburst,
	input  logic             arvalid,
	output logic             arready,
	output logic [3:0]       rid,
	output cache_pkg::word_t rdata,
	output logic [1:0]       rresp,
	output logic             rlast,
	output logic             rvalid,
	input  logic             rready,
	output int               ar_count,
	output cache_pkg::addr_t last_araddr,
	output logic [3:0]       last_arlen,
	output logic [3:0]       last_arid,
	output logic [2:0]       last_arsize,
	output logic [1:0]       last_arburst
);
	import cache_pkg::*;

	localparam beat_t LAST_BEAT = beat_t'(`CACHE_LINE_WORDS - 1);

	integer seed = 32'hd038;
	logic   busy;
	addr_t  base;
	beat_t  beat;

	assign rid   = 4'd0;
	assign rresp = 2'b00;

	// Word at byte address A is A xor 5A5A0000
	assign rdata = (base + (addr_t'(beat) << 2)) ^ 32'h5A5A0000;
	assign rlast = rvalid && (beat == LAST_BEAT);

	always @(posedge clk or negedge arst_n) begin
		logic coin;
		if (!arst_n) begin
			arready      <= 1'b0;
			rvalid       <= 1'b0;
			busy         <= 1'b0;
			base         <= '0;
			beat         <= '0;
			ar_count     <= 0;
			last_araddr  <= '0;
			last_arlen   <= '0;
			last_arid    <= '0;
			last_arsize  <= '0;
			last_arburst <= '0;
		end else begin
			// One draw per cycle and a set coin means stall
			coin = stall_en && (($random(seed) & 1) != 0);
			if (!busy) begin
				if (arvalid && arready) begin
					busy         <= 1'b1;
					arready      <= 1'b0;
					base         <= araddr;
					beat         <= '0;
					ar_count     <= ar_count + 1;
					last_araddr  <= araddr;
					last_arlen   <= arlen;
					last_arid    <= arid;
					last_arsize  <= arsize;
					last_arburst <= arburst;
				end else begin
					arready <= !coin;
				end
			end else if (rvalid && rready) begin
				beat <= beat + beat_t'(1);
				if (rlast) begin
					busy   <= 1'b0;
					rvalid <= 1'b0;
				end else begin
					rvalid <= !coin;
				end
			end else if (!rvalid) begin
				rvalid <= !coin;
			end
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk
);
	localparam int PERIOD_NS = 40;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk = ~clk;
		end
	end

endmodule

/* cache_controller.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_controller (
	input  logic              clk,
	input  logic              arst_n,
	// CPU fetch bus
	input  logic              ibus_read,
	input  cache_pkg::addr_t  ibus_addr,
	input  logic              ibus_flush,
	output cache_pkg::fetch_t ibus_rdata,
	output logic              ibus_valid,
	// AXI AR
	output logic [3:0]        arid,
	output cache_pkg::addr_t  araddr,
	output logic [3:0]        arlen,
	output logic [2:0]        arsize,
	output logic [1:0]        arburst,
	output logic              arvalid,
	input  logic              arready,
	// AXI R, error responses are not acted on
	input  logic [3:0]        rid,
	input  cache_pkg::word_t  rdata,
	input  logic [1:0]        rresp,
	input  logic              rlast,
	input  logic              rvalid,
	output logic              rready
);
	import cache_pkg::*;

	logic   lookup;
	index_t lookup_index;
	tag_t   lookup_tag;
	logic   hit;
	logic   install;
	index_t install_index;
	tag_t   install_tag;
	logic   refill_start;
	addr_t  refill_addr;
	logic   refill_done;
	logic   beat_valid;
	beat_t  beat_num;
	word_t  beat_data;
	index_t rd_index;
	logic [1:0] rd_pair;

	icache_ctrl ctrl_inst (
		.clk,
		.arst_n,
		.ibus_read,
		.ibus_addr,
		.ibus_valid,
		.lookup,
		.lookup_index,
		.lookup_tag,
		.hit,
		.install,
		.install_index,
		.install_tag,
		.refill_start,
		.refill_addr,
		.refill_done,
		.rd_index,
		.rd_pair
	);

	icache_tag_array tag_inst (
		.clk,
		.arst_n,
		.flush (ibus_flush),
		.lookup,
		.lookup_index,
		.lookup_tag,
		.install,
		.install_index,
		.install_tag,
		.hit
	);

	// Refill always targets the set of the held request
	icache_data_array data_inst (
		.clk,
		.beat_valid,
		.beat_index (install_index),
		.beat_num,
		.beat_data,
		.rd_index,
		.rd_pair,
		.rd_data    (ibus_rdata)
	);

	axi_burst_reader axi_inst (
		.clk,
		.arst_n,
		.refill_start,
		.refill_addr,
		.arid,
		.araddr,
		.arlen,
		.arsize,
		.arburst,
		.arvalid,
		.arready,
		.rdata,
		.rlast,
		.rvalid,
		.rready,
		.beat_valid,
		.beat_num,
		.beat_data,
		.refill_done
	);

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_ctrl (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              ibus_read,
	input  cache_pkg::addr_t  ibus_addr,
	output logic              ibus_valid,
	output logic              lookup,
	output cache_pkg::index_t lookup_index,
	output cache_pkg::tag_t   lookup_tag,
	input  logic              hit,
	output logic              install,
	output cache_pkg::index_t install_index,
	output cache_pkg::tag_t   install_tag,
	output logic              refill_start,
	output cache_pkg::addr_t  refill_addr,
	input  logic              refill_done,
	output cache_pkg::index_t rd_index,
	output logic [1:0]        rd_pair
);
	import cache_pkg::*;

	ctrl_state_t state;
	addr_t       req_addr;
	tag_t        req_tag;
	index_t      req_index;
	logic        lookup_q;
	logic        checking;

	// Held request split into its fields
	assign req_tag   = req_addr[`CACHE_ADDR_LEN-1 -: `CACHE_TAG_LEN];
	assign req_index = req_addr[`CACHE_OFFSET_LEN +: `CACHE_INDEX_LEN];
	assign rd_index  = req_index;
	assign rd_pair   = req_addr[`CACHE_OFFSET_LEN-1 -: 2];

	assign lookup_index  = req_index;
	assign lookup_tag    = req_tag;
	assign install_index = req_index;
	assign install_tag   = req_tag;
	assign refill_addr   = req_addr;

	// First LOOKUP cycle probes the tags and the second one sees hit
	assign lookup   = (state == LOOKUP) && !lookup_q;
	assign checking = (state == LOOKUP) && lookup_q;

	assign ibus_valid   = checking && hit;
	assign refill_start = checking && !hit;
	assign install      = (state == INSTALL);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			lookup_q <= 1'b0;
		end else begin
			lookup_q <= lookup;
			case (state)
				IDLE: begin
					if (ibus_read) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (checking) begin
						state <= hit ? IDLE : REFILL;
					end
				end
				REFILL: begin
					if (refill_done) begin
						state <= INSTALL;
					end
				end
				INSTALL: begin
					// Probe again so the hit path returns the data
					state <= LOOKUP;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && ibus_read) begin
			req_addr <= ibus_addr;
		end
	end

	// The line just installed must hit on the repeated probe
	a_hit_after_install: assert property (
		@(posedge clk) disable iff (!arst_n)
		install |-> ##2 !refill_start
	);

endmodule

/* axi_burst_reader.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module axi_burst_reader (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             refill_start,
	input  cache_pkg::addr_t refill_addr,
	// AXI AR
	output logic [3:0]       arid,
	output cache_pkg::addr_t araddr,
	output logic [3:0]       arlen,
	output logic [2:0]       arsize,
	output logic [1:0]       arburst,
	output logic             arvalid,
	input  logic             arready,
	// AXI R
	input  cache_pkg::word_t rdata,
	input  logic             rlast,
	input  logic             rvalid,
	output logic             rready,
	// Beats toward the data array
	output logic             beat_valid,
	output cache_pkg::beat_t beat_num,
	output cache_pkg::word_t beat_data,
	output logic             refill_done
);
	import cache_pkg::*;

	localparam beat_t LAST_BEAT = beat_t'(`CACHE_LINE_WORDS - 1);

	addr_t line_addr;
	beat_t beat_cnt;

	// Fixed INCR burst of one line, 4 bytes per beat
	assign arid    = 4'd0;
	assign arlen   = 4'(`CACHE_LINE_WORDS - 1);
	assign arsize  = 3'd2;
	assign arburst = 2'b01;
	assign araddr  = line_addr;

	assign beat_valid  = rvalid && rready;
	assign beat_num    = beat_cnt;
	assign beat_data   = rdata;
	assign refill_done = beat_valid && rlast;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arvalid  <= 1'b0;
			rready   <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (refill_start) begin
				arvalid <= 1'b1;
			end else if (arvalid && arready) begin
				arvalid  <= 1'b0;
				rready   <= 1'b1;
				beat_cnt <= '0;
			end
			if (beat_valid) begin
				beat_cnt <= beat_cnt + 1'b1;
				if (rlast) begin
					rready <= 1'b0;
				end
			end
		end
	end

	// Line-aligned start address
	always_ff @(posedge clk) begin
		if (refill_start) begin
			line_addr <= {refill_addr[`CACHE_ADDR_LEN-1:`CACHE_OFFSET_LEN],
				{`CACHE_OFFSET_LEN{1'b0}}};
		end
	end

	a_ar_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr)
	);

	// Memory must close the burst on the eighth beat, never earlier or later
	a_rlast_on_last_beat: assert property (
		@(posedge clk) disable iff (!arst_n)
		beat_valid |-> (rlast == (beat_cnt == LAST_BEAT))
	);

endmodule

/* icache_data_array.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_data_array (
	input  logic              clk,
	input  logic              beat_valid,
	input  cache_pkg::index_t beat_index,
	input  cache_pkg::beat_t  beat_num,
	input  cache_pkg::word_t  beat_data,
	input  cache_pkg::index_t rd_index,
	input  logic [1:0]        rd_pair,
	output cache_pkg::fetch_t rd_data
);
	import cache_pkg::*;

	localparam int PAIRS = `CACHE_LINE_WORDS / 2;
	localparam int DEPTH = `CACHE_SETS * PAIRS;

	// Even words hold the lower address of each pair
	word_t bank_even [DEPTH];
	word_t bank_odd  [DEPTH];

	logic [`CACHE_INDEX_LEN+1:0] wr_addr;
	logic [`CACHE_INDEX_LEN+1:0] rd_addr;

	assign wr_addr = {beat_index, beat_num[2:1]};
	assign rd_addr = {rd_index, rd_pair};

	// One word per refill beat
	always_ff @(posedge clk) begin
		if (beat_valid) begin
			if (beat_num[0]) begin
				bank_odd[wr_addr] <= beat_data;
			end else begin
				bank_even[wr_addr] <= beat_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= {bank_odd[rd_addr], bank_even[rd_addr]};
	end

endmodule

/* icache_tag_array.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_tag_array (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              flush,
	input  logic              lookup,
	input  cache_pkg::index_t lookup_index,
	input  cache_pkg::tag_t   lookup_tag,
	input  logic              install,
	input  cache_pkg::index_t install_index,
	input  cache_pkg::tag_t   install_tag,
	output logic              hit
);
	import cache_pkg::*;

	tag_t                   tags [`CACHE_SETS];
	logic [`CACHE_SETS-1:0] valid;

	// Valid bits and the registered compare result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			hit   <= 1'b0;
		end else begin
			if (flush) begin
				valid <= '0;
			end else if (install) begin
				valid[install_index] <= 1'b1;
			end
			if (lookup) begin
				hit <= valid[lookup_index] && (tags[lookup_index] == lookup_tag);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (install) begin
			tags[install_index] <= install_tag;
		end
	end

	// Flush comes from the CPU only while no fetch is in flight
	a_no_install_during_flush: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(install && flush)
	);

endmodule

/* cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

	// Byte address on the fetch bus and on AXI
	typedef logic [`CACHE_ADDR_LEN-1:0] addr_t;

	// Address fields
	typedef logic [`CACHE_TAG_LEN-1:0]   tag_t;
	typedef logic [`CACHE_INDEX_LEN-1:0] index_t;

	// Word number inside a line, also the AXI beat number
	typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0] beat_t;

	// One AXI beat
	typedef logic [31:0] word_t;

	// Two instructions
	typedef logic [`CACHE_FETCH_WIDTH-1:0] fetch_t;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL,
		INSTALL
	} ctrl_state_t;

endpackage

/* cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Byte address and CPU fetch sizes
`define CACHE_ADDR_LEN    32
`define CACHE_FETCH_WIDTH 64

// Direct-mapped geometry, 8 words of 32 bits per line
`define CACHE_LINE_WORDS  8
`define CACHE_SETS        16

// Address split into tag, index and byte offset
`define CACHE_INDEX_LEN   4
`define CACHE_OFFSET_LEN  5
`define CACHE_TAG_LEN     (`CACHE_ADDR_LEN - `CACHE_INDEX_LEN - `CACHE_OFFSET_LEN)

`endif
